// File: Makefile
TOP = memAccessTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -Mdir obj_dir -f flist.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf obj_dir

// File: dv/memAccessTb.sv
// Directed testbench for the memory-access block; run through flist.f with memAccessTb as top.
module memAccessTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MemWords   = 256;
    localparam int MemLatency = 3;
    localparam int OpCount    = 44; // Valid ops and bubbles sent by all tests.
    localparam int TimeLimit  = OpCount * (MemLatency + 4) * 10 + 600;

    logic                clk;
    logic                rst;
    pipePkg::ExMaBundle  exIn;
    pipePkg::MaWbBundle  wbOut;
    pipePkg::BypassWrite bypass;
    logic                stall;
    logic                flushReq;
    rvPkg::word_t        nextPc;
    logic                invalidateICache;
    rvPkg::word_t        opCommitCount;

    string               testName;
    rvPkg::word_t        rngState = 32'h469f;
    int                  sentOps = 0;
    int                  stallCycles;
    logic                lastFlush;
    logic                lastInval;
    rvPkg::word_t        lastNextPc;
    pipePkg::BypassWrite lastBypass;
    pipePkg::MaWbBundle  lastWb;
    logic [7:0]          refBytes [4*MemWords]; // Byte image of the data memory.

    memAccessTop #(.MemWords(MemWords), .MemLatency(MemLatency)) dut (.*);

    bind memAccessTop memAccessChk chk (.clk(clk), .rst(rst), .wbOut(wbOut), .bypass(bypass),
        .stall(stall), .flushReq(flushReq), .invalidateICache(invalidateICache),
        .opCommitCount(opCommitCount));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(TimeLimit);
        reportFailure("Timeout: the tests did not finish in the expected time");
    end

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic checkValue(input string what, input logic [31:0] expected,
            input logic [31:0] actual);
        if (actual !== expected) begin
            reportFailure($sformatf("[ERROR] %s: %s expected 0x%08h actual 0x%08h",
                testName, what, expected, actual));
        end
    endtask

    function automatic rvPkg::word_t xorshift(input rvPkg::word_t x);
        rvPkg::word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic rvPkg::word_t randomWord();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic int accessBytes(input rvPkg::LoadStoreType t);
        case (t)
            rvPkg::LoadStoreType_Word:  return 4;
            rvPkg::LoadStoreType_Half,
            rvPkg::LoadStoreType_HalfU: return 2;
            default:                    return 1;
        endcase
    endfunction

    // Little-endian byte writes into the model.
    function automatic void refStore(input rvPkg::word_t addr, input rvPkg::LoadStoreType t,
            input rvPkg::word_t value);
        for (int i = 0; i < accessBytes(t); i++) begin
            refBytes[addr + i] = value[i*8 +: 8];
        end
    endfunction

    function automatic rvPkg::word_t refLoad(input rvPkg::word_t addr,
            input rvPkg::LoadStoreType t);
        rvPkg::word_t raw;
        raw = '0;
        for (int i = 0; i < accessBytes(t); i++) begin
            raw[i*8 +: 8] = refBytes[addr + i];
        end
        case (t)
            rvPkg::LoadStoreType_Byte: return {{24{raw[7]}}, raw[7:0]};
            rvPkg::LoadStoreType_Half: return {{16{raw[15]}}, raw[15:0]};
            default:                   return raw; // Unsigned sizes are already zero-filled.
        endcase
    endfunction

    function automatic pipePkg::ExMaBundle baseOp();
        pipePkg::ExMaBundle b;
        b = '0;
        b.valid = 1'b1;
        b.pc = 32'h1000 + rvPkg::word_t'(sentOps) * rvPkg::InsnSize;
        return b;
    endfunction

    function automatic pipePkg::ExMaBundle memOp(input logic store, input rvPkg::word_t addr,
            input rvPkg::LoadStoreType t, input rvPkg::word_t value);
        pipePkg::ExMaBundle b;
        b = baseOp();
        b.op.isLoad = !store;
        b.op.isStore = store;
        b.op.regWriteEnable = !store;
        b.op.regWriteFromMemory = !store;
        b.op.loadStoreType = t;
        b.memAddr = addr;
        b.storeValue = value;
        b.dstRegAddr = store ? 5'd0 : 5'd10;
        return b;
    endfunction

    // Presents one op, holds it through the stall and captures the final cycle and wbOut.
    task automatic runOp(input pipePkg::ExMaBundle op);
        int expectStall;
        expectStall = (op.valid && !op.trapInfo.valid &&
            (op.op.isLoad || op.op.isStore || op.op.isFenceI)) ? MemLatency : 0;
        stallCycles = 0;
        @(posedge clk);
        exIn <= op;
        @(negedge clk);
        while (stall) begin
            stallCycles++;
            checkValue("wbOut valid during stall", 0, wbOut.valid);
            checkValue("flush or invalidate during stall", 0, {flushReq, invalidateICache});
            @(negedge clk);
        end
        checkValue("stall cycles", expectStall, stallCycles);
        lastFlush = flushReq;
        lastInval = invalidateICache;
        lastNextPc = nextPc;
        lastBypass = bypass;
        @(posedge clk);
        exIn <= '0;
        @(negedge clk);
        lastWb = wbOut;
        checkValue("wbOut valid after the op", op.valid, wbOut.valid);
        if (op.valid) begin
            checkValue("wbOut pc", op.pc, wbOut.pc);
            checkValue("wbOut dstRegAddr", 32'(op.dstRegAddr), 32'(wbOut.dstRegAddr));
            checkValue("wbOut op", 32'(op.op), 32'(wbOut.op));
            sentOps++;
        end
    endtask

    task automatic doStore(input rvPkg::word_t addr, input rvPkg::LoadStoreType t,
            input rvPkg::word_t value);
        runOp(memOp(1'b1, addr, t, value));
        refStore(addr, t, value);
        checkValue("store trap", 0, lastWb.trapInfo.valid);
    endtask

    task automatic doLoad(input rvPkg::word_t addr, input rvPkg::LoadStoreType t);
        rvPkg::word_t expected;
        expected = refLoad(addr, t);
        runOp(memOp(1'b0, addr, t, '0));
        checkValue("load value", expected, lastWb.dstIntValue);
        checkValue("bypass enable", 1, lastBypass.enable);
        checkValue("bypass addr", 32'd10, 32'(lastBypass.addr));
        checkValue("bypass value", expected, lastBypass.value);
    endtask

    task automatic faultCheck(input pipePkg::ExMaBundle op, input rvPkg::ExceptionCode cause);
        runOp(op);
        checkValue("trap valid", 1, lastWb.trapInfo.valid);
        checkValue("trap cause", 32'(cause), 32'(lastWb.trapInfo.cause));
        checkValue("trap value", op.memAddr, lastWb.trapInfo.value);
        checkValue("flush on fault", 1, lastFlush);
        checkValue("bypass on fault", 0, lastBypass.enable);
    endtask

    task automatic storeLoadTest();
        rvPkg::word_t wordAddr [4] = '{32'h00, 32'h04, 32'h08, 32'h1C};
        rvPkg::word_t halfAddr [4] = '{32'h0A, 32'h12, 32'h1C, 32'h1E};
        rvPkg::word_t byteAddr [4] = '{32'h05, 32'h13, 32'h1D, 32'h1E};
        testName = "storeLoad";
        for (int i = 0; i < 8; i++) begin
            doStore(4 * i, rvPkg::LoadStoreType_Word, (i == 7) ? 32'hFF80_7F01 : randomWord());
        end
        doStore(32'h05, rvPkg::LoadStoreType_Byte, randomWord());
        doStore(32'h0A, rvPkg::LoadStoreType_Half, randomWord());
        doStore(32'h13, rvPkg::LoadStoreType_ByteU, randomWord());
        for (int i = 0; i < 4; i++) begin
            doLoad(wordAddr[i], rvPkg::LoadStoreType_Word);
            doLoad(halfAddr[i], rvPkg::LoadStoreType_Half);
            doLoad(halfAddr[i], rvPkg::LoadStoreType_HalfU);
            doLoad(byteAddr[i], rvPkg::LoadStoreType_Byte);
            doLoad(byteAddr[i], rvPkg::LoadStoreType_ByteU);
        end
    endtask

    task automatic latencyTest();
        pipePkg::ExMaBundle b;
        testName = "latency";
        doLoad(32'h08, rvPkg::LoadStoreType_Word); // Stall count checked in runOp.
        b = baseOp();
        b.op.regWriteEnable = 1'b1;
        b.dstRegAddr = 5'd3;
        b.dstIntValue = randomWord();
        runOp(b);
        checkValue("alu result", b.dstIntValue, lastWb.dstIntValue);
        checkValue("alu bypass", 0, lastBypass.enable);
    endtask

    task automatic faultTest();
        pipePkg::ExMaBundle b;
        testName = "fault";
        faultCheck(memOp(1'b0, 32'h400, rvPkg::LoadStoreType_Word, '0),
            rvPkg::ExceptionCode_LoadPageFault);
        faultCheck(memOp(1'b0, 32'h7F0, rvPkg::LoadStoreType_ByteU, '0),
            rvPkg::ExceptionCode_LoadPageFault);
        faultCheck(memOp(1'b1, 32'h06, rvPkg::LoadStoreType_Word, randomWord()),
            rvPkg::ExceptionCode_StorePageFault);
        faultCheck(memOp(1'b1, 32'h09, rvPkg::LoadStoreType_Half, randomWord()),
            rvPkg::ExceptionCode_StorePageFault);
        doLoad(32'h04, rvPkg::LoadStoreType_Word); // Words under the failed stores.
        doLoad(32'h08, rvPkg::LoadStoreType_Word);
        b = memOp(1'b0, 32'h10, rvPkg::LoadStoreType_Word, '0);
        b.trapInfo.valid = 1'b1;
        b.trapInfo.cause = rvPkg::ExceptionCode_LoadPageFault;
        b.trapInfo.value = 32'h0000_0F00;
        runOp(b);
        checkValue("incoming trap valid", 1, lastWb.trapInfo.valid);
        checkValue("incoming trap value", 32'h0000_0F00, lastWb.trapInfo.value);
        checkValue("incoming trap flush", 1, lastFlush);
    endtask

    task automatic redirectTest();
        pipePkg::ExMaBundle b;
        testName = "redirect";
        b = baseOp();
        b.op.isBranch = 1'b1;
        b.branchTaken = 1'b1;
        b.branchTarget = 32'h2000;
        runOp(b);
        checkValue("taken flush", 1, lastFlush);
        checkValue("taken nextPc", 32'h2000, lastNextPc);
        b = baseOp();
        b.op.isBranch = 1'b1;
        b.branchTarget = 32'h3000;
        runOp(b);
        checkValue("not-taken flush", 0, lastFlush);
        checkValue("not-taken nextPc", b.pc + rvPkg::InsnSize, lastNextPc);
    endtask

    task automatic fenceTest();
        pipePkg::ExMaBundle b;
        testName = "fence";
        b = baseOp();
        b.op.isFenceI = 1'b1;
        runOp(b);
        checkValue("invalidate", 1, lastInval);
        checkValue("fence flush", 1, lastFlush);
    endtask

    task automatic commitTest();
        pipePkg::ExMaBundle b;
        testName = "commit";
        b = memOp(1'b0, 32'h00, rvPkg::LoadStoreType_Word, '0);
        b.valid = 1'b0; // Bubble.
        runOp(b);
        checkValue("commit count", sentOps, opCommitCount);
    endtask

    initial begin
        rst = 1'b1;
        exIn = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        storeLoadTest();
        latencyTest();
        faultTest();
        redirectTest();
        fenceTest();
        commitTest();
        if (dut.chk.failCount == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            reportFailure("Concurrent assertions failed during the run");
        end
    end

endmodule

// File: dv/memAccess_chk.sv
// Concurrent checks on the memory-access top level, attached to it by a bind in the testbench.
module memAccessChk (
    input logic                clk,
    input logic                rst,
    input pipePkg::MaWbBundle  wbOut,
    input pipePkg::BypassWrite bypass,
    input logic                stall,
    input logic                flushReq,
    input logic                invalidateICache,
    input rvPkg::word_t        opCommitCount
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0; // Number of assertion failures so far.

    bubbleOnStall: assert property (@(posedge clk) disable iff (rst) stall |=> !wbOut.valid)
        else begin
            failCount++;
            $error("wbOut valid in the cycle after a stall");
        end

    noFlushWhileStalled: assert property (@(posedge clk) disable iff (rst) !(flushReq && stall))
        else begin
            failCount++;
            $error("flushReq high together with stall");
        end

    // Reset leaves every strobe low and the counter cleared.
    quietAfterReset: assert property (@(posedge clk) rst |=> (!wbOut.valid && !flushReq &&
        !stall && !invalidateICache && !bypass.enable && opCommitCount == '0))
        else begin
            failCount++;
            $error("outputs not idle after reset");
        end

endmodule

// File: flist.f
source/rvPkg.sv
source/pipePkg.sv
source/loadStoreUnit.sv
source/memAccessStage.sv
source/pipelineCtrl.sv
source/memAccessTop.sv
dv/memAccess_chk.sv
dv/memAccessTb.sv

// File: source/loadStoreUnit.sv
// Word-organized data memory with a fixed access latency, serving requests from the memory-access stage.
module loadStoreUnit #(
    parameter int MemWords   = 256,
    parameter int MemLatency = 3
) (
    input  logic            clk,
    input  logic            rst,
    input  pipePkg::LsuReq  req,
    output pipePkg::LsuResp resp
);
    localparam int IndexWidth = (MemWords > 1) ? $clog2(MemWords) : 1;
    localparam int CountWidth = $clog2(MemLatency + 1);

    rvPkg::word_t mem [MemWords];

    logic [CountWidth-1:0] cycleCount;
    logic                  done;
    logic                  isLoad;
    logic                  isStore;
    logic                  inRange;
    logic                  misaligned;
    logic                  fault;
    logic [IndexWidth-1:0] wordIndex;
    logic [4:0]            shiftAmount;
    logic [3:0]            byteEnable;
    rvPkg::word_t          readWord;
    rvPkg::word_t          shiftedWord;
    rvPkg::word_t          loadValue;
    rvPkg::word_t          storeShifted;
    rvPkg::word_t          mergedWord;

    // Cycle counter runs only while a request is held.
    always_ff @(posedge clk) begin
        if (rst || !req.enable || done) begin
            cycleCount <= '0;
        end else begin
            cycleCount <= cycleCount + 1'b1;
        end
    end

    assign done = req.enable && (cycleCount == CountWidth'(MemLatency));

    assign isLoad      = req.command == pipePkg::LsuCommand_Load;
    assign isStore     = req.command == pipePkg::LsuCommand_Store;
    assign inRange     = req.addr[31:2] < 30'(MemWords);
    assign wordIndex   = req.addr[IndexWidth+1:2];
    assign shiftAmount = {req.addr[1:0], 3'b000};
    assign readWord    = inRange ? mem[wordIndex] : '0;

    always_comb begin
        case (req.loadStoreType)
            rvPkg::LoadStoreType_Half,
            rvPkg::LoadStoreType_HalfU: misaligned = req.addr[0];
            rvPkg::LoadStoreType_Word:  misaligned = req.addr[1:0] != 2'b00;
            default:                    misaligned = 1'b0;
        endcase
    end

    // Invalidate never faults.
    assign fault = done && (isLoad || isStore) && (!inRange || misaligned);

    // Load path: align the addressed bytes to bit 0, then extend.
    assign shiftedWord = readWord >> shiftAmount;

    always_comb begin
        case (req.loadStoreType)
            rvPkg::LoadStoreType_Byte:  loadValue = {{24{shiftedWord[7]}}, shiftedWord[7:0]};
            rvPkg::LoadStoreType_Half:  loadValue = {{16{shiftedWord[15]}}, shiftedWord[15:0]};
            rvPkg::LoadStoreType_ByteU: loadValue = {24'b0, shiftedWord[7:0]};
            rvPkg::LoadStoreType_HalfU: loadValue = {16'b0, shiftedWord[15:0]};
            default:                    loadValue = readWord;
        endcase
    end

    // Store path: byte lanes selected by size and offset.
    assign storeShifted = req.storeValue << shiftAmount;

    always_comb begin
        case (req.loadStoreType)
            rvPkg::LoadStoreType_Byte,
            rvPkg::LoadStoreType_ByteU: byteEnable = 4'b0001 << req.addr[1:0];
            rvPkg::LoadStoreType_Half,
            rvPkg::LoadStoreType_HalfU: byteEnable = 4'b0011 << req.addr[1:0];
            default:                    byteEnable = 4'b1111;
        endcase
        for (int i = 0; i < 4; i++) begin
            mergedWord[i*8 +: 8] = byteEnable[i] ? storeShifted[i*8 +: 8] : readWord[i*8 +: 8];
        end
    end

    // Memory is written only in the done cycle of a clean store.
    always_ff @(posedge clk) begin
        if (done && isStore && !fault) begin
            mem[wordIndex] <= mergedWord;
        end
    end

    always_comb begin
        resp.done   = done;
        resp.fault  = fault;
        resp.result = (done && isLoad && !fault) ? loadValue : '0;
    end

endmodule

// File: source/memAccessStage.sv
// Memory-access stage: issues LSU commands, merges load data, raises faults and registers the writeback bundle.
module memAccessStage (
    input  logic               clk,
    input  logic               rst,
    input  pipePkg::ExMaBundle exIn,
    input  logic               stall,
    output pipePkg::LsuReq     lsuReq,
    input  pipePkg::LsuResp    lsuResp,
    output pipePkg::MaWbBundle wbOut,
    output pipePkg::BypassWrite bypass,
    output logic               memBusy,
    output logic               opValid,
    output logic               redirect,
    output logic               branchTaken,
    output rvPkg::word_t       branchTarget,
    output rvPkg::word_t       pc,
    output logic               invalidateICache
);
    pipePkg::MaOp     op;
    pipePkg::TrapInfo trapInfo;
    rvPkg::word_t     dstIntValue;

    assign op = exIn.op;

    // Command decode and request; an op that already carries a trap stays off the memory.
    always_comb begin
        if (op.isLoad) begin
            lsuReq.command = pipePkg::LsuCommand_Load;
        end else if (op.isStore) begin
            lsuReq.command = pipePkg::LsuCommand_Store;
        end else if (op.isFenceI) begin
            lsuReq.command = pipePkg::LsuCommand_Invalidate;
        end else begin
            lsuReq.command = pipePkg::LsuCommand_None;
        end
        lsuReq.enable = exIn.valid && (op.isLoad || op.isStore || op.isFenceI) &&
            !exIn.trapInfo.valid;
        lsuReq.addr          = exIn.memAddr;
        lsuReq.loadStoreType = op.loadStoreType;
        lsuReq.storeValue    = exIn.storeValue;
    end

    assign memBusy = lsuReq.enable && !lsuResp.done;

    // Incoming trap wins over a fault found here.
    always_comb begin
        trapInfo = exIn.trapInfo;
        if (exIn.valid && !exIn.trapInfo.valid && lsuResp.done && lsuResp.fault) begin
            trapInfo.valid = 1'b1;
            trapInfo.cause = op.isStore ? rvPkg::ExceptionCode_StorePageFault :
                rvPkg::ExceptionCode_LoadPageFault;
            trapInfo.value = exIn.memAddr;
        end
    end

    assign dstIntValue = op.regWriteFromMemory ? lsuResp.result : exIn.dstIntValue;

    // Signals for the controller.
    assign opValid      = exIn.valid;
    assign branchTaken  = op.isBranch && exIn.branchTaken;
    assign branchTarget = exIn.branchTarget;
    assign pc           = exIn.pc;
    assign redirect     = exIn.valid && (branchTaken || op.isFenceI || trapInfo.valid);

    assign invalidateICache = exIn.valid && op.isFenceI && !stall;

    always_comb begin
        bypass.enable = exIn.valid && op.isLoad && op.regWriteEnable && !trapInfo.valid &&
            !stall;
        bypass.addr  = exIn.dstRegAddr;
        bypass.value = dstIntValue;
    end

    // Output register, bubble while stalled.
    always_ff @(posedge clk) begin
        if (rst || stall) begin
            wbOut.valid          <= 1'b0;
            wbOut.trapInfo.valid <= 1'b0;
        end else begin
            wbOut.valid          <= exIn.valid;
            wbOut.trapInfo.valid <= trapInfo.valid;
        end
        wbOut.op             <= exIn.op;
        wbOut.pc             <= exIn.pc;
        wbOut.dstRegAddr     <= exIn.dstRegAddr;
        wbOut.dstIntValue    <= dstIntValue;
        wbOut.trapInfo.cause <= trapInfo.cause;
        wbOut.trapInfo.value <= trapInfo.value;
    end

endmodule

// File: source/memAccessTop.sv
// Top level of the memory-access block: joins the stage, the controller and the load-store unit.
module memAccessTop #(
    parameter int MemWords   = 256,
    parameter int MemLatency = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  pipePkg::ExMaBundle  exIn,
    output pipePkg::MaWbBundle  wbOut,
    output pipePkg::BypassWrite bypass,
    output logic                stall,
    output logic                flushReq,
    output rvPkg::word_t        nextPc,
    output logic                invalidateICache,
    output rvPkg::word_t        opCommitCount
);
    pipePkg::LsuReq  lsuReq;
    pipePkg::LsuResp lsuResp;
    logic            memBusy;
    logic            opValid;
    logic            redirect;
    logic            branchTaken;
    rvPkg::word_t    branchTarget;
    rvPkg::word_t    pc;

    memAccessStage stage (
        .clk(clk),
        .rst(rst),
        .exIn(exIn),
        .stall(stall),
        .lsuReq(lsuReq),
        .lsuResp(lsuResp),
        .wbOut(wbOut),
        .bypass(bypass),
        .memBusy(memBusy),
        .opValid(opValid),
        .redirect(redirect),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .pc(pc),
        .invalidateICache(invalidateICache)
    );

    pipelineCtrl ctrl (
        .clk(clk),
        .rst(rst),
        .memBusy(memBusy),
        .opValid(opValid),
        .redirect(redirect),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .pc(pc),
        .stall(stall),
        .flushReq(flushReq),
        .nextPc(nextPc),
        .opCommitCount(opCommitCount)
    );

    loadStoreUnit #(
        .MemWords(MemWords),
        .MemLatency(MemLatency)
    ) lsu (
        .clk(clk),
        .rst(rst),
        .req(lsuReq),
        .resp(lsuResp)
    );

endmodule

// File: source/pipePkg.sv
// Pipeline bundles and the load-store command set shared by the memory-access stage and its neighbours.
package pipePkg;

    // Commands issued by the stage to the load-store unit.
    typedef enum logic [1:0] {
        LsuCommand_None       = 2'd0,
        LsuCommand_Load       = 2'd1,
        LsuCommand_Store      = 2'd2,
        LsuCommand_Invalidate = 2'd3 // Instruction fence.
    } LsuCommand;

    // Decoded control bits that follow an op down the pipe.
    typedef struct packed {
        logic               isLoad;
        logic               isStore;
        logic               isFenceI;
        logic               isBranch;
        logic               regWriteEnable;
        rvPkg::LoadStoreType loadStoreType;
        logic               regWriteFromMemory; // Writeback value comes from the LSU.
    } MaOp;

    typedef struct packed {
        logic               valid;
        rvPkg::ExceptionCode cause;
        rvPkg::word_t       value; // Faulting address.
    } TrapInfo;

    // Execute to memory-access.
    typedef struct packed {
        logic           valid;
        MaOp            op;
        rvPkg::word_t   pc;
        rvPkg::word_t   memAddr;
        rvPkg::word_t   storeValue;
        rvPkg::regAddr_t dstRegAddr;
        rvPkg::word_t   dstIntValue; // ALU result for non-load ops.
        logic           branchTaken;
        rvPkg::word_t   branchTarget;
        TrapInfo        trapInfo;    // Trap raised by an earlier stage.
    } ExMaBundle;

    // Memory-access to writeback, registered.
    typedef struct packed {
        logic           valid;
        MaOp            op;
        rvPkg::word_t   pc;
        rvPkg::regAddr_t dstRegAddr;
        rvPkg::word_t   dstIntValue;
        TrapInfo        trapInfo;
    } MaWbBundle;

    // Held steady from the first enable cycle until done.
    typedef struct packed {
        logic               enable;
        LsuCommand          command;
        rvPkg::word_t       addr;
        rvPkg::LoadStoreType loadStoreType;
        rvPkg::word_t       storeValue;
    } LsuReq;

    typedef struct packed {
        logic         done;   // One-cycle completion strobe.
        logic         fault;  // Only meaningful with done.
        rvPkg::word_t result; // Extended load data.
    } LsuResp;

    // Early integer write for the load bypass path.
    typedef struct packed {
        logic           enable;
        rvPkg::regAddr_t addr;
        rvPkg::word_t   value;
    } BypassWrite;

endpackage

// File: source/pipelineCtrl.sv
// Pipeline controller for the memory-access stage: stall, flush and next-PC decisions, and commit counting.
module pipelineCtrl (
    input  logic         clk,
    input  logic         rst,
    input  logic         memBusy,
    input  logic         opValid,
    input  logic         redirect,
    input  logic         branchTaken,
    input  rvPkg::word_t branchTarget,
    input  rvPkg::word_t pc,
    output logic         stall,
    output logic         flushReq,
    output rvPkg::word_t nextPc,
    output rvPkg::word_t opCommitCount
);
    // Hold everything upstream until the LSU completes.
    assign stall = memBusy;

    // A redirect takes effect only in the op's last cycle.
    assign flushReq = redirect && !stall;

    always_comb begin
        if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pc + rvPkg::InsnSize; // Fall through.
        end
    end

    // An op commits when it leaves the stage unstalled.
    always_ff @(posedge clk) begin
        if (rst) begin
            opCommitCount <= '0;
        end else if (opValid && !stall) begin
            opCommitCount <= opCommitCount + 1'b1;
        end
    end

endmodule

// File: source/rvPkg.sv
// RV32 ISA-level types and constants, referenced by scoped name from the pipeline sources.
package rvPkg;

    // Basic integer data word.
    typedef logic [31:0] word_t;

    // Integer register index, x0 to x31.
    typedef logic [4:0] regAddr_t;

    // Access size and extension for loads and stores.
    typedef enum logic [2:0] {
        LoadStoreType_Byte  = 3'd0, // Signed byte.
        LoadStoreType_Half  = 3'd1, // Signed halfword.
        LoadStoreType_Word  = 3'd2,
        LoadStoreType_ByteU = 3'd3, // Zero-extended byte.
        LoadStoreType_HalfU = 3'd4  // Zero-extended halfword.
    } LoadStoreType;

    // mcause values for the memory faults raised in this stage.
    typedef enum logic [3:0] {
        ExceptionCode_LoadPageFault  = 4'd13,
        ExceptionCode_StorePageFault = 4'd15
    } ExceptionCode;

    // Every instruction is a full 32-bit encoding, no compressed set.
    localparam word_t InsnSize = 32'd4;

endpackage
